// ==== verilog/ex_pkg.sv ====
// Execute stage types

package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and plain vector types
  ////////////////////////////////////////////////////////////////////////////

  // Data width of the RV32 datapath
  localparam int word_w = 32;

  // Operand, result or program counter
  typedef logic [word_w-1:0] word_t;

  // Register file index
  typedef logic [4:0] reg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////////////////////

  // ALU operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu
  } alu_op_e;

  // Branch comparisons
  typedef enum logic [2:0] {
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } branch_op_e;

  // Divide and remainder operations
  typedef enum logic [1:0] {
    div_div,
    div_divu,
    div_rem,
    div_remu
  } div_op_e;

  // Divider FSM states
  typedef enum logic [1:0] {
    div_idle,
    div_busy,
    div_done
  } div_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline and control bundles
  ////////////////////////////////////////////////////////////////////////////

  // Instruction from decode
  typedef struct packed {
    logic       instr_valid;
    logic       alu_en;
    logic       branch_en;
    logic       div_en;
    alu_op_e    alu_op;
    branch_op_e branch_op;
    div_op_e    div_op;
    word_t      operand_a;
    word_t      operand_b;
    // Branch target
    word_t      operand_c;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    word_t      pc;
  } id_ex_pipe_t;

  // Registered result towards write-back
  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    word_t     pc;
    logic      branch_taken;
  } ex_wb_pipe_t;

  // Controller inputs
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
    logic data_ind_timing;
  } ctrl_t;

endpackage

// ==== verilog/ex_alu.sv ====
// Integer ALU

`timescale 1ns/1ns

module ex_alu import ex_pkg::*; (
  // Operation select
  input  alu_op_e op_i,
  // Operands
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  // Result
  output word_t   result_o
);

  // Shift amount from the low five bits of operand b
  logic [4:0] shamt;

  // Shared adder and comparison results
  word_t sum;
  word_t diff;
  logic  lt_signed;
  logic  lt_unsigned;

  assign shamt = operand_b_i[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic and compare
  ////////////////////////////////////////////////////////////////////////////

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Signed order
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  // Unsigned order
  assign lt_unsigned = operand_a_i < operand_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op_i)
      alu_add: begin
        result_o = sum;
      end
      alu_sub: begin
        result_o = diff;
      end
      // Bitwise logic
      alu_and: begin
        result_o = operand_a_i & operand_b_i;
      end
      alu_or: begin
        result_o = operand_a_i | operand_b_i;
      end
      alu_xor: begin
        result_o = operand_a_i ^ operand_b_i;
      end
      // Shifts
      alu_sll: begin
        result_o = operand_a_i << shamt;
      end
      alu_srl: begin
        result_o = operand_a_i >> shamt;
      end
      alu_sra: begin
        // Arithmetic shift keeps the sign bit
        result_o = word_t'($signed(operand_a_i) >>> shamt);
      end
      // Set-less-than gives 1 or 0
      alu_slt: begin
        result_o = {{(word_w-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        result_o = {{(word_w-1){1'b0}}, lt_unsigned};
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// ==== verilog/ex_branch_unit.sv ====
// Branch compare and target

`timescale 1ns/1ns

module ex_branch_unit import ex_pkg::*; (
  // Comparison and operands
  input  branch_op_e op_i,
  input  word_t      operand_a_i,
  input  word_t      operand_b_i,
  input  word_t      target_i,
  input  logic       branch_en_i,
  // Constant time branch mode
  input  logic       data_ind_timing_i,
  // Fall-through PCs
  input  logic       id_pc_valid_i,
  input  word_t      id_pc_i,
  input  word_t      pc_if_i,
  // Decision to fetch
  output logic       decision_o,
  output word_t      target_o,
  // True outcome
  output logic       taken_o
);

  logic cmp;

  // Raw comparison
  always_comb begin
    unique case (op_i)
      br_eq:   cmp = operand_a_i == operand_b_i;
      br_ne:   cmp = operand_a_i != operand_b_i;
      br_lt:   cmp = $signed(operand_a_i) < $signed(operand_b_i);
      br_ge:   cmp = $signed(operand_a_i) >= $signed(operand_b_i);
      br_ltu:  cmp = operand_a_i < operand_b_i;
      br_geu:  cmp = operand_a_i >= operand_b_i;
      default: cmp = 1'b0;
    endcase
  end

  assign taken_o = cmp && branch_en_i;

  always_comb begin
    if (data_ind_timing_i) begin
      // Every branch redirects fetch
      decision_o = branch_en_i;
      if (cmp) begin
        target_o = target_i;
      end else if (id_pc_valid_i) begin
        // Not taken, resume at the decode PC
        target_o = id_pc_i;
      end else begin
        // Nothing in decode, resume at fetch
        target_o = pc_if_i;
      end
    end else begin
      decision_o = taken_o;
      target_o   = target_i;
    end
  end

endmodule

// ==== verilog/ex_divider.sv ====
// Iterative integer divider

`timescale 1ns/1ns

module ex_divider import ex_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // Operation and operands
  input  div_op_e op_i,
  input  word_t   dividend_i,
  input  word_t   divisor_i,
  // Low drops any operation in flight
  input  logic    abort_n_i,
  // Request handshake
  input  logic    valid_i,
  output logic    ready_o,
  // Result handshake
  output logic    valid_o,
  input  logic    ready_i,
  output word_t   result_o
);

  localparam int cnt_w = $clog2(word_w);

  // Control state
  div_state_e       state_q;
  div_state_e       state_d;
  logic [cnt_w-1:0] cnt_q;

  // Datapath registers
  word_t rem_q;
  word_t quo_q;
  word_t divisor_q;
  logic  neg_quo_q;
  logic  neg_rem_q;
  logic  is_rem_q;

  // Operand preparation
  logic  op_signed;
  logic  dividend_neg;
  logic  divisor_neg;
  word_t dividend_abs;
  word_t divisor_abs;

  // One restoring step
  logic [word_w:0]   rem_shift;
  logic [word_w+1:0] diff;

  logic  accept;
  logic  last_iter;
  word_t quo_fixed;
  word_t rem_fixed;

  ////////////////////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////////////////////

  assign op_signed    = (op_i == div_div) || (op_i == div_rem);
  assign dividend_neg = op_signed && dividend_i[word_w-1];
  assign divisor_neg  = op_signed && divisor_i[word_w-1];
  // Magnitudes, the most negative value maps to itself as unsigned
  assign dividend_abs = dividend_neg ? -dividend_i : dividend_i;
  assign divisor_abs  = divisor_neg ? -divisor_i : divisor_i;

  assign accept    = (state_q == div_idle) && valid_i;
  assign last_iter = cnt_q == cnt_w'(word_w - 1);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      div_idle: if (valid_i) state_d = div_busy;
      div_busy: if (last_iter) state_d = div_done;
      div_done: if (ready_i) state_d = div_idle;
      default:  state_d = div_idle;
    endcase
    // Abort wins in every state
    if (!abort_n_i) begin
      state_d = div_idle;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= div_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        cnt_q <= '0;
      end else if (state_q == div_busy) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Bring down the next dividend bit
  assign rem_shift = {rem_q, quo_q[word_w-1]};
  // Borrow in the top bit means the divisor does not fit
  assign diff      = {1'b0, rem_shift} - {2'b00, divisor_q};

  always_ff @(posedge clk) begin
    if (accept) begin
      rem_q     <= '0;
      quo_q     <= dividend_abs;
      divisor_q <= divisor_abs;
      // Divide by zero keeps the all ones quotient
      neg_quo_q <= (dividend_neg ^ divisor_neg) && (divisor_i != '0);
      neg_rem_q <= dividend_neg;
      is_rem_q  <= (op_i == div_rem) || (op_i == div_remu);
    end else if (state_q == div_busy) begin
      rem_q <= diff[word_w+1] ? rem_shift[word_w-1:0] : diff[word_w-1:0];
      quo_q <= {quo_q[word_w-2:0], ~diff[word_w+1]};
    end
  end

  // Sign fix-up, remainder follows the dividend
  assign quo_fixed = neg_quo_q ? -quo_q : quo_q;
  assign rem_fixed = neg_rem_q ? -rem_q : rem_q;
  assign result_o  = is_rem_q ? rem_fixed : quo_fixed;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  assign valid_o = state_q == div_done;
  assign ready_o = ((state_q == div_idle) && !valid_i) ||
                   ((state_q == div_done) && ready_i);

endmodule

// ==== verilog/ex_wb_pipe.sv ====
// EX/WB pipeline register

`timescale 1ns/1ns

module ex_wb_pipe import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Instruction and controller
  input  id_ex_pipe_t id_ex_pipe_i,
  input  ctrl_t       ctrl_i,
  // Unit results
  input  word_t       alu_result_i,
  input  word_t       div_result_i,
  input  logic        div_valid_i,
  input  logic        div_ready_i,
  input  logic        branch_taken_i,
  // From write-back
  input  logic        wb_ready_i,
  // Divider request
  output logic        div_start_o,
  // Forwarding value
  output word_t       rf_wdata_o,
  // Stage handshake
  output logic        ex_ready_o,
  output logic        ex_valid_o,
  output ex_wb_pipe_t ex_wb_pipe_o
);

  logic live;
  logic handoff;

  // Control part of the register
  logic instr_valid_q;
  logic rf_we_q;
  logic branch_taken_q;

  // Payload part of the register
  reg_addr_t rf_waddr_q;
  word_t     rf_wdata_q;
  word_t     pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////////////////////

  // Killed or halted instructions do nothing
  assign live = id_ex_pipe_i.instr_valid && !ctrl_i.kill_ex && !ctrl_i.halt_ex;

  assign div_start_o = id_ex_pipe_i.div_en && live;

  // Single cycle units are valid at once, divide waits for the divider
  assign ex_valid_o = live && (id_ex_pipe_i.alu_en || id_ex_pipe_i.branch_en ||
                               (id_ex_pipe_i.div_en && div_valid_i));

  // Kill always frees the stage
  assign ex_ready_o = ctrl_i.kill_ex || (div_ready_i && wb_ready_i && !ctrl_i.halt_ex);

  assign handoff = ex_valid_o && wb_ready_i;

  // Write port mux
  assign rf_wdata_o = id_ex_pipe_i.div_en ? div_result_i : alu_result_i;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q  <= 1'b0;
      rf_we_q        <= 1'b0;
      branch_taken_q <= 1'b0;
    end else if (handoff) begin
      instr_valid_q  <= 1'b1;
      rf_we_q        <= id_ex_pipe_i.rf_we;
      branch_taken_q <= branch_taken_i;
    end else if (wb_ready_i) begin
      // Bubble
      instr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (handoff) begin
      pc_q <= id_ex_pipe_i.pc;
      // Write data only follows a real register write
      if (id_ex_pipe_i.rf_we) begin
        rf_waddr_q <= id_ex_pipe_i.rf_waddr;
        rf_wdata_q <= rf_wdata_o;
      end
    end
  end

  assign ex_wb_pipe_o.instr_valid  = instr_valid_q;
  assign ex_wb_pipe_o.rf_we        = rf_we_q;
  assign ex_wb_pipe_o.rf_waddr     = rf_waddr_q;
  assign ex_wb_pipe_o.rf_wdata     = rf_wdata_q;
  assign ex_wb_pipe_o.pc           = pc_q;
  assign ex_wb_pipe_o.branch_taken = branch_taken_q;

endmodule

// ==== verilog/ex_stage.sv ====
// RV32 execute stage

`timescale 1ns/1ns

module ex_stage import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // From decode
  input  id_ex_pipe_t id_ex_pipe_i,
  // From controller
  input  ctrl_t       ctrl_i,
  // Fetch and decode PCs
  input  word_t       pc_if_i,
  input  logic        id_pc_valid_i,
  input  word_t       id_pc_i,
  // From write-back
  input  logic        wb_ready_i,
  // To write-back
  output ex_wb_pipe_t ex_wb_pipe_o,
  // Forwarding to decode
  output word_t       rf_wdata_o,
  // Branch to fetch
  output logic        branch_decision_o,
  output word_t       branch_target_o,
  // Stage handshake
  output logic        ex_ready_o,
  output logic        ex_valid_o
);

  word_t alu_result;
  word_t div_result;
  logic  div_valid;
  logic  div_ready;
  logic  div_start;
  logic  branch_taken;

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu i_ex_alu (
    .op_i        (id_ex_pipe_i.alu_op),
    .operand_a_i (id_ex_pipe_i.operand_a),
    .operand_b_i (id_ex_pipe_i.operand_b),
    .result_o    (alu_result)
  );

  ex_branch_unit i_ex_branch_unit (
    .op_i              (id_ex_pipe_i.branch_op),
    .operand_a_i       (id_ex_pipe_i.operand_a),
    .operand_b_i       (id_ex_pipe_i.operand_b),
    .target_i          (id_ex_pipe_i.operand_c),
    .branch_en_i       (id_ex_pipe_i.branch_en),
    .data_ind_timing_i (ctrl_i.data_ind_timing),
    .id_pc_valid_i     (id_pc_valid_i),
    .id_pc_i           (id_pc_i),
    .pc_if_i           (pc_if_i),
    .decision_o        (branch_decision_o),
    .target_o          (branch_target_o),
    .taken_o           (branch_taken)
  );

  // Abort follows the raw enable, not kill or halt
  ex_divider i_ex_divider (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_i       (id_ex_pipe_i.div_op),
    .dividend_i (id_ex_pipe_i.operand_a),
    .divisor_i  (id_ex_pipe_i.operand_b),
    .abort_n_i  (id_ex_pipe_i.div_en),
    .valid_i    (div_start),
    .ready_o    (div_ready),
    .valid_o    (div_valid),
    .ready_i    (wb_ready_i),
    .result_o   (div_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  ex_wb_pipe i_ex_wb_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_ex_pipe_i   (id_ex_pipe_i),
    .ctrl_i         (ctrl_i),
    .alu_result_i   (alu_result),
    .div_result_i   (div_result),
    .div_valid_i    (div_valid),
    .div_ready_i    (div_ready),
    .branch_taken_i (branch_taken),
    .wb_ready_i     (wb_ready_i),
    .div_start_o    (div_start),
    .rf_wdata_o     (rf_wdata_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o),
    .ex_wb_pipe_o   (ex_wb_pipe_o)
  );

endmodule

// ==== verification/ex_stage_tb.sv ====
// Execute stage testbench

`timescale 1ns/1ns

module ex_stage_tb import ex_pkg::*; ();

  // Run length, also sets the cycle limit
  localparam int num_tests        = 6;
  localparam int num_instr        = 200;
  localparam int cycles_per_instr = 40;
  localparam int max_cycles       = num_tests * num_instr * cycles_per_instr;
  localparam word_t sign_bit      = 32'h8000_0000;

  logic        clk;
  logic        rst_n;
  id_ex_pipe_t id_ex_pipe;
  ctrl_t       ctrl;
  word_t       pc_if;
  logic        id_pc_valid;
  word_t       id_pc;
  logic        wb_ready;
  ex_wb_pipe_t ex_wb_pipe;
  word_t       rf_wdata;
  logic        branch_decision;
  word_t       branch_target;
  logic        ex_ready;
  logic        ex_valid;

  int          cycles;
  int          checks;
  int          errors;
  int          test_err_base;
  int unsigned seed_ret;

  // Last destination and data that reached write-back
  reg_addr_t   last_waddr;
  word_t       last_wdata;

  ex_stage i_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe),
    .ctrl_i            (ctrl),
    .pc_if_i           (pc_if),
    .id_pc_valid_i     (id_pc_valid),
    .id_pc_i           (id_pc),
    .wb_ready_i        (wb_ready),
    .ex_wb_pipe_o      (ex_wb_pipe),
    .rf_wdata_o        (rf_wdata),
    .branch_decision_o (branch_decision),
    .branch_target_o   (branch_target),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Stop a stuck run
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT never completed the handshake", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    logic [63:0] ext;
    // Sign extend then shift right logically
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or:  return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: return ext[31:0];
      // Flipping the sign bit turns signed order into unsigned order
      alu_slt: return word_t'((a ^ sign_bit) < (b ^ sign_bit));
      default: return word_t'(a < b);
    endcase
  endfunction

  function automatic logic branch_model(input branch_op_e op, input word_t a, input word_t b);
    logic lt_s;
    lt_s = (a ^ sign_bit) < (b ^ sign_bit);
    case (op)
      br_eq:   return a == b;
      br_ne:   return a != b;
      br_lt:   return lt_s;
      br_ge:   return !lt_s;
      br_ltu:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t div_model(input div_op_e op, input word_t a, input word_t b);
    int sa;
    int sb;
    sa = $signed(a);
    sb = $signed(b);
    // Divide by zero
    if (b == 32'h0) begin
      return (op == div_div || op == div_divu) ? 32'hffff_ffff : a;
    end
    // Signed overflow
    if ((op == div_div || op == div_rem) && a == sign_bit && b == 32'hffff_ffff) begin
      return (op == div_div) ? a : 32'h0;
    end
    case (op)
      div_div:  return word_t'(sa / sb);
      div_rem:  return word_t'(sa % sb);
      div_divu: return a / b;
      default:  return a % b;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic id_ex_pipe_t make_alu(input int n);
    id_ex_pipe_t instr;
    instr             = '0;
    instr.instr_valid = 1'b1;
    instr.alu_en      = 1'b1;
    instr.alu_op      = alu_op_e'(4'(n % 10));
    instr.operand_a   = $urandom();
    instr.operand_b   = $urandom();
    instr.rf_we       = 1'b1;
    instr.rf_waddr    = 5'($urandom());
    instr.pc          = $urandom();
    return instr;
  endfunction

  function automatic id_ex_pipe_t make_branch(input int n);
    id_ex_pipe_t instr;
    instr             = '0;
    instr.instr_valid = 1'b1;
    instr.branch_en   = 1'b1;
    instr.branch_op   = branch_op_e'(3'(n % 6));
    instr.operand_a   = $urandom();
    // Equal operands often enough to hit both outcomes of eq and ne
    instr.operand_b   = ($urandom_range(0, 3) == 0) ? instr.operand_a : $urandom();
    instr.operand_c   = $urandom();
    instr.pc          = $urandom();
    return instr;
  endfunction

  function automatic id_ex_pipe_t make_div(input int n);
    id_ex_pipe_t instr;
    instr             = '0;
    instr.instr_valid = 1'b1;
    instr.div_en      = 1'b1;
    instr.div_op      = div_op_e'(2'(n % 4));
    instr.operand_a   = $urandom();
    case ($urandom_range(0, 7))
      0: instr.operand_b = 32'h0;
      1: begin
        instr.operand_a = sign_bit;
        instr.operand_b = 32'hffff_ffff;
      end
      // Spread the divisor size
      default: instr.operand_b = $urandom() >> $urandom_range(0, 31);
    endcase
    instr.rf_we       = 1'b1;
    instr.rf_waddr    = 5'($urandom());
    instr.pc          = $urandom();
    return instr;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input word_t exp, input word_t act);
    checks++;
    assert (exp === act) else begin
      $display("Error %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("%s at cycle %0d", what, cycles);
      errors++;
    end
  endtask

  // Ends on the falling edge of the handoff cycle
  task automatic wait_handoff(input bit backpressure);
    ex_wb_pipe_t held;
    bit          stalled;
    forever begin
      @(negedge clk);
      if (ex_valid && wb_ready) begin
        break;
      end
      stalled = !wb_ready;
      held    = ex_wb_pipe;
      if (stalled) begin
        check_value("ex_ready_o", 32'h0, word_t'(ex_ready));
      end
      @(posedge clk);
      #1;
      if (stalled) begin
        check_true(ex_wb_pipe == held, "EX/WB register changed while write-back stalled");
      end
      if (backpressure) begin
        wb_ready = ($urandom_range(0, 2) != 0);
      end
    end
  endtask

  // Registered result after the handoff edge, then a bubble from decode
  task automatic check_wb(input id_ex_pipe_t instr, input word_t exp_wdata, input logic taken);
    @(posedge clk);
    #1;
    id_ex_pipe = '0;
    check_value("ex_wb_pipe_o.instr_valid", 32'h1, word_t'(ex_wb_pipe.instr_valid));
    check_value("ex_wb_pipe_o.rf_we", word_t'(instr.rf_we), word_t'(ex_wb_pipe.rf_we));
    check_value("ex_wb_pipe_o.pc", instr.pc, ex_wb_pipe.pc);
    check_value("ex_wb_pipe_o.branch_taken", word_t'(taken),
                word_t'(ex_wb_pipe.branch_taken));
    if (instr.rf_we) begin
      check_value("ex_wb_pipe_o.rf_waddr", word_t'(instr.rf_waddr),
                  word_t'(ex_wb_pipe.rf_waddr));
      check_value("ex_wb_pipe_o.rf_wdata", exp_wdata, ex_wb_pipe.rf_wdata);
      last_waddr = instr.rf_waddr;
      last_wdata = exp_wdata;
    end else begin
      // No register write, destination and data keep the last write
      check_value("ex_wb_pipe_o.rf_waddr", word_t'(last_waddr),
                  word_t'(ex_wb_pipe.rf_waddr));
      check_value("ex_wb_pipe_o.rf_wdata", last_wdata, ex_wb_pipe.rf_wdata);
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s finished with %0d errors", num, name, errors - test_err_base);
    test_err_base = errors;
  endtask

  // Killed or halted cycle, nothing may reach write-back
  task automatic check_blocked(input logic exp_ready, input string what);
    @(negedge clk);
    check_true(!ex_valid, {what, " instruction reported valid"});
    check_value("ex_ready_o", word_t'(exp_ready), word_t'(ex_ready));
    @(posedge clk);
    #1;
    check_true(!ex_wb_pipe.instr_valid, {what, " instruction was handed off"});
  endtask

  task automatic run_branches(input logic dit);
    id_ex_pipe_t instr;
    logic        cmp;
    word_t       exp_target;
    ctrl.data_ind_timing = dit;
    for (int i = 0; i < num_instr; i++) begin
      instr       = make_branch(i);
      pc_if       = $urandom();
      id_pc       = $urandom();
      id_pc_valid = 1'($urandom());
      id_ex_pipe  = instr;
      wait_handoff(1'b0);
      cmp        = branch_model(instr.branch_op, instr.operand_a, instr.operand_b);
      exp_target = (!dit || cmp) ? instr.operand_c : (id_pc_valid ? id_pc : pc_if);
      check_value("branch_decision_o", word_t'(dit ? 1'b1 : cmp), word_t'(branch_decision));
      check_value("branch_target_o", exp_target, branch_target);
      check_wb(instr, 32'h0, cmp);
    end
    ctrl.data_ind_timing = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    id_ex_pipe_t instr;
    word_t       exp;
    seed_ret    = $urandom(32'hff6b44c2);
    rst_n       = 1'b0;
    id_ex_pipe  = '0;
    ctrl        = '0;
    pc_if       = '0;
    id_pc_valid = 1'b0;
    id_pc       = '0;
    wb_ready    = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle stage after reset
    @(negedge clk);
    check_value("ex_wb_pipe_o.instr_valid", 32'h0, word_t'(ex_wb_pipe.instr_valid));
    check_value("ex_wb_pipe_o.rf_we", 32'h0, word_t'(ex_wb_pipe.rf_we));
    check_value("ex_wb_pipe_o.branch_taken", 32'h0, word_t'(ex_wb_pipe.branch_taken));
    check_value("ex_ready_o", 32'h1, word_t'(ex_ready));
    check_value("ex_valid_o", 32'h0, word_t'(ex_valid));
    @(posedge clk);
    #1;
    report_test(1, "reset");

    for (int i = 0; i < num_instr; i++) begin
      instr      = make_alu(i);
      exp        = alu_model(instr.alu_op, instr.operand_a, instr.operand_b);
      id_ex_pipe = instr;
      wait_handoff(1'b0);
      check_value("rf_wdata_o", exp, rf_wdata);
      check_wb(instr, exp, 1'b0);
    end
    report_test(2, "alu");

    run_branches(1'b0);
    report_test(3, "branch");
    run_branches(1'b1);
    report_test(4, "branch constant time");

    // Write-back stalls at random during divides
    for (int i = 0; i < num_instr; i++) begin
      instr      = make_div(i);
      exp        = div_model(instr.div_op, instr.operand_a, instr.operand_b);
      id_ex_pipe = instr;
      wb_ready   = ($urandom_range(0, 2) != 0);
      wait_handoff(1'b1);
      check_value("rf_wdata_o", exp, rf_wdata);
      check_wb(instr, exp, 1'b0);
    end
    wb_ready = 1'b1;
    report_test(5, "divide");

    // Killed on arrival
    for (int i = 0; i < 20; i++) begin
      case (i % 3)
        0: instr = make_alu(i);
        1: instr = make_branch(i);
        default: instr = make_div(i);
      endcase
      ctrl.kill_ex = 1'b1;
      id_ex_pipe   = instr;
      repeat (3) check_blocked(1'b1, "Killed");
      ctrl.kill_ex = 1'b0;
      id_ex_pipe   = '0;
    end
    // Killed mid divide, then a fresh divide
    for (int i = 0; i < 20; i++) begin
      id_ex_pipe = make_div(i);
      repeat ($urandom_range(2, 25)) @(posedge clk);
      #1;
      ctrl.kill_ex = 1'b1;
      check_blocked(1'b1, "Killed divide");
      ctrl.kill_ex = 1'b0;
      id_ex_pipe   = '0;
      // Divider stays busy until the abort edge
      check_blocked(1'b0, "Aborted divide");
      instr      = make_div(i + 1);
      exp        = div_model(instr.div_op, instr.operand_a, instr.operand_b);
      id_ex_pipe = instr;
      wait_handoff(1'b0);
      check_wb(instr, exp, 1'b0);
    end
    // Halted for a few cycles, then released
    for (int i = 0; i < 20; i++) begin
      instr        = make_alu(i);
      exp          = alu_model(instr.alu_op, instr.operand_a, instr.operand_b);
      ctrl.halt_ex = 1'b1;
      id_ex_pipe   = instr;
      repeat ($urandom_range(2, 6)) check_blocked(1'b0, "Halted");
      ctrl.halt_ex = 1'b0;
      wait_handoff(1'b0);
      check_wb(instr, exp, 1'b0);
    end
    report_test(6, "kill and halt");

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_divider.sv
verilog/ex_wb_pipe.sv
verilog/ex_stage.sv
verification/ex_stage_tb.sv

// ==== Makefile ====
# Verilator build for the execute stage testbench

VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := ex_stage_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
